/* common/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CACHE_WAYS         4
`define CACHE_SETS         16
`define CACHE_SET_BITS     4
`define CACHE_OFFSET_BITS  5
`define CACHE_TAG_BITS     23
`define CACHE_LINE_BITS    256

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CACHE_TAG_MSB      31
`define CACHE_TAG_LSB      9
`define CACHE_SET_MSB      8
`define CACHE_SET_LSB      5
`define CACHE_WORD_MSB     4   // Word select inside the line
`define CACHE_WORD_LSB     2

`endif

/* common/cache_pkg.sv */
package cache_pkg;

    typedef enum logic [1:0] {
        WAY_A,
        WAY_B,
        WAY_C,
        WAY_D
    } way_t;

    typedef enum logic [1:0] {
        ARR_IDLE,        // Read only
        ARR_HIT_WRITE,   // Masked word into the hit way, sets dirty
        ARR_FILL,        // Whole line into the victim, clean and valid
        ARR_HOLD         // Arrays stay selected while memory works
    } array_op_t;

    typedef enum logic [1:0] {
        LK_HIT,
        LK_MISS_CLEAN,
        LK_MISS_DIRTY
    } lookup_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE
    } fsm_state_t;

endpackage

/* common/mem_pkg.sv */
`include "cache_params.svh"

package mem_pkg;

    // Processor side
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_mask_t;

    // Memory side moves whole lines
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;

endpackage

/* source/sram_array.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module sram_array #(
    parameter int WIDTH = 256
) (
    input  logic                       clk,
    input  logic                       select,     // Active low
    input  logic                       write_en,   // Active low
    input  logic [(WIDTH+7)/8-1:0]     byte_mask,
    input  logic [`CACHE_SET_BITS-1:0] addr,
    input  logic [WIDTH-1:0]           wdata,
    output logic [WIDTH-1:0]           rdata
);

    logic [WIDTH-1:0] mem [`CACHE_SETS];
    logic [WIDTH-1:0] merged;

    always_comb begin
        merged = mem[addr];
        for (int i = 0; i < WIDTH; i++) begin
            if (byte_mask[i / 8]) begin
                merged[i] = wdata[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and read register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!select) begin
            if (!write_en) begin
                mem[addr] <= merged;
                rdata <= merged;      // Written word shows on the port next cycle
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* source/ff_array.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module ff_array #(
    parameter int WIDTH = 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       select,     // Active low
    input  logic                       write_en,   // Active low
    input  logic [`CACHE_SET_BITS-1:0] addr,
    input  logic [WIDTH-1:0]           wdata,
    output logic [WIDTH-1:0]           rdata
);

    logic [WIDTH-1:0] mem [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (!select) begin
            if (!write_en) begin
                mem[addr] <= wdata;
                rdata <= wdata;       // Same write-first port as sram_array
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* cache/cache_fsm.sv */
`timescale 1ns/1ns

module cache_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 request,
    input  logic                 is_write,
    input  cache_pkg::lookup_t   lookup,
    input  logic                 dfp_resp,
    output cache_pkg::array_op_t array_op,
    output logic                 ufp_resp,
    output logic                 dfp_read,
    output logic                 dfp_write
);

    cache_pkg::fsm_state_t state;
    cache_pkg::fsm_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        array_op = cache_pkg::ARR_IDLE;
        ufp_resp = 1'b0;
        dfp_read = 1'b0;
        dfp_write = 1'b0;
        case (state)
            cache_pkg::ST_IDLE: begin
                if (request) begin
                    state_next = cache_pkg::ST_COMPARE;   // Arrays read at this edge
                end
            end
            cache_pkg::ST_COMPARE: begin
                case (lookup)
                    cache_pkg::LK_HIT: begin
                        ufp_resp = 1'b1;
                        if (is_write) begin
                            array_op = cache_pkg::ARR_HIT_WRITE;
                        end
                        state_next = cache_pkg::ST_IDLE;
                    end
                    cache_pkg::LK_MISS_CLEAN: begin
                        state_next = cache_pkg::ST_ALLOCATE;
                    end
                    cache_pkg::LK_MISS_DIRTY: begin
                        state_next = cache_pkg::ST_WRITEBACK;
                    end
                    default: begin
                        state_next = cache_pkg::ST_IDLE;
                    end
                endcase
            end
            cache_pkg::ST_WRITEBACK: begin
                dfp_write = 1'b1;
                array_op = cache_pkg::ARR_HOLD;       // Victim data must stay on the read port
                if (dfp_resp) begin
                    state_next = cache_pkg::ST_ALLOCATE;
                end
            end
            cache_pkg::ST_ALLOCATE: begin
                dfp_read = 1'b1;
                array_op = cache_pkg::ARR_HOLD;
                if (dfp_resp) begin
                    array_op = cache_pkg::ARR_FILL;
                    state_next = cache_pkg::ST_COMPARE;   // Refilled line hits next cycle
                end
            end
            default: begin
                state_next = cache_pkg::ST_IDLE;
            end
        endcase
    end

    a_dfp_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(dfp_read && dfp_write)
    ) else $error("dfp_read and dfp_write high together");

    a_resp_pulse: assert property (
        @(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp
    ) else $error("ufp_resp held longer than one cycle");

endmodule

/* cache/hit_miss.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module hit_miss (
    input  logic [`CACHE_TAG_BITS:0]   tag_a,   // Dirty bit above the tag
    input  logic [`CACHE_TAG_BITS:0]   tag_b,
    input  logic [`CACHE_TAG_BITS:0]   tag_c,
    input  logic [`CACHE_TAG_BITS:0]   tag_d,
    input  logic                       valid_a,
    input  logic                       valid_b,
    input  logic                       valid_c,
    input  logic                       valid_d,
    input  logic [`CACHE_TAG_BITS-1:0] curr_tag,
    input  cache_pkg::way_t            replace_way,
    output cache_pkg::lookup_t         lookup,
    output cache_pkg::way_t            visit_way
);

    logic [`CACHE_TAG_BITS:0] tags [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]   valids;
    logic [`CACHE_WAYS-1:0]   match;

    assign tags = '{tag_a, tag_b, tag_c, tag_d};
    assign valids = {valid_d, valid_c, valid_b, valid_a};

    always_comb begin
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            match[i] = valids[i] && (tags[i][`CACHE_TAG_BITS-1:0] == curr_tag);
        end
    end

    always_comb begin
        if (valids[replace_way] && tags[replace_way][`CACHE_TAG_BITS]) begin
            lookup = cache_pkg::LK_MISS_DIRTY;
        end else begin
            lookup = cache_pkg::LK_MISS_CLEAN;
        end
        visit_way = replace_way;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (match[i]) begin
                lookup = cache_pkg::LK_HIT;
                visit_way = cache_pkg::way_t'(i);
            end
        end
    end

    // A line is only ever filled on a miss, so a tag lives in one way of a set
    always_comb begin
        a_single_match: assert final ($isunknown(match) || $onehot0(match))
            else $error("Tag matches in more than one way");
    end

endmodule

/* cache/plru.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module plru (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       update,
    input  logic [`CACHE_SET_BITS-1:0] set,
    input  cache_pkg::way_t            visit_way,
    output cache_pkg::way_t            replace_way
);

    logic [2:0] tree_bits [`CACHE_SETS];   // {b2, b1, b0} per set
    logic [2:0] curr_bits;
    logic [2:0] next_bits;

    assign curr_bits = tree_bits[set];

    // b0 picks the half, b1 or b2 the way inside it
    always_comb begin
        if (!curr_bits[0]) begin
            replace_way = curr_bits[1] ? cache_pkg::WAY_B : cache_pkg::WAY_A;
        end else begin
            replace_way = curr_bits[2] ? cache_pkg::WAY_D : cache_pkg::WAY_C;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Point the tree away from the way just used
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_bits = curr_bits;
        case (visit_way)
            cache_pkg::WAY_A: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b1;
            end
            cache_pkg::WAY_B: begin
                next_bits[0] = 1'b1;
                next_bits[1] = 1'b0;
            end
            cache_pkg::WAY_C: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b1;
            end
            default: begin
                next_bits[0] = 1'b0;
                next_bits[2] = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                tree_bits[i] <= '0;
            end
        end else if (update) begin
            tree_bits[set] <= next_bits;
        end
    end

endmodule

/* cache/cache.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module cache (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::addr_t      ufp_addr,
    input  mem_pkg::byte_mask_t ufp_rmask,
    input  mem_pkg::byte_mask_t ufp_wmask,
    output mem_pkg::word_t      ufp_rdata,
    input  mem_pkg::word_t      ufp_wdata,
    output logic                ufp_resp,
    output mem_pkg::addr_t      dfp_addr,
    output logic                dfp_read,
    output logic                dfp_write,
    input  mem_pkg::line_t      dfp_rdata,
    output mem_pkg::line_t      dfp_wdata,
    input  logic                dfp_resp
);

    localparam int WORD_BITS  = $bits(mem_pkg::word_t);
    localparam int LINE_WORDS = `CACHE_LINE_BITS / WORD_BITS;
    localparam int LINE_BYTES = `CACHE_LINE_BITS / 8;
    localparam int TAG_BYTES  = (`CACHE_TAG_BITS + 1 + 7) / 8;

    logic [`CACHE_TAG_BITS-1:0]                curr_tag;
    logic [`CACHE_SET_BITS-1:0]                curr_set;
    logic [`CACHE_WORD_MSB-`CACHE_WORD_LSB:0]  curr_word;
    logic                                      request;
    logic                                      is_write;
    logic                                      array_select;   // Active low

    cache_pkg::array_op_t array_op;
    cache_pkg::lookup_t   lookup;
    cache_pkg::way_t      visit_way;
    cache_pkg::way_t      replace_way;
    cache_pkg::way_t      write_way;

    mem_pkg::line_t           data_rdata   [`CACHE_WAYS];
    logic [`CACHE_TAG_BITS:0] tag_rdata    [`CACHE_WAYS];
    logic                     valid_rdata  [`CACHE_WAYS];
    logic                     way_write_en [`CACHE_WAYS];   // Active low

    mem_pkg::line_t           line_wdata;
    logic [LINE_BYTES-1:0]    line_mask;
    logic [`CACHE_TAG_BITS:0] tag_wdata;

    assign curr_tag = ufp_addr[`CACHE_TAG_MSB:`CACHE_TAG_LSB];
    assign curr_set = ufp_addr[`CACHE_SET_MSB:`CACHE_SET_LSB];
    assign curr_word = ufp_addr[`CACHE_WORD_MSB:`CACHE_WORD_LSB];

    assign request = (|ufp_rmask) || (|ufp_wmask);
    assign is_write = |ufp_wmask;
    assign array_select = !(request || (array_op != cache_pkg::ARR_IDLE));

    assign ufp_rdata = data_rdata[visit_way][curr_word * WORD_BITS +: WORD_BITS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        write_way = (array_op == cache_pkg::ARR_FILL) ? replace_way : visit_way;
        line_wdata = dfp_rdata;
        line_mask = '1;
        tag_wdata = {1'b0, curr_tag};
        if (array_op == cache_pkg::ARR_HIT_WRITE) begin
            line_wdata = {LINE_WORDS{ufp_wdata}};   // Mask picks the word lane
            line_mask = LINE_BYTES'(ufp_wmask) << (curr_word * (WORD_BITS / 8));
            tag_wdata = {1'b1, curr_tag};
        end
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            way_write_en[i] = 1'b1;
        end
        if ((array_op == cache_pkg::ARR_HIT_WRITE) || (array_op == cache_pkg::ARR_FILL)) begin
            way_write_en[write_way] = 1'b0;
        end
    end

    // Victim tag forms the write-back address
    always_comb begin
        dfp_wdata = data_rdata[replace_way];
        if (dfp_write) begin
            dfp_addr = {tag_rdata[replace_way][`CACHE_TAG_BITS-1:0], curr_set,
                        {`CACHE_OFFSET_BITS{1'b0}}};
        end else begin
            dfp_addr = {curr_tag, curr_set, {`CACHE_OFFSET_BITS{1'b0}}};
        end
    end

    cache_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .request   (request),
        .is_write  (is_write),
        .lookup    (lookup),
        .dfp_resp  (dfp_resp),
        .array_op  (array_op),
        .ufp_resp  (ufp_resp),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write)
    );

    hit_miss u_hit_miss (
        .tag_a       (tag_rdata[cache_pkg::WAY_A]),
        .tag_b       (tag_rdata[cache_pkg::WAY_B]),
        .tag_c       (tag_rdata[cache_pkg::WAY_C]),
        .tag_d       (tag_rdata[cache_pkg::WAY_D]),
        .valid_a     (valid_rdata[cache_pkg::WAY_A]),
        .valid_b     (valid_rdata[cache_pkg::WAY_B]),
        .valid_c     (valid_rdata[cache_pkg::WAY_C]),
        .valid_d     (valid_rdata[cache_pkg::WAY_D]),
        .curr_tag    (curr_tag),
        .replace_way (replace_way),
        .lookup      (lookup),
        .visit_way   (visit_way)
    );

    plru u_plru (
        .clk         (clk),
        .rst         (rst),
        .update      (ufp_resp),
        .set         (curr_set),
        .visit_way   (visit_way),
        .replace_way (replace_way)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage, one set of arrays per way
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        sram_array #(.WIDTH(`CACHE_LINE_BITS)) u_data (
            .clk       (clk),
            .select    (array_select),
            .write_en  (way_write_en[w]),
            .byte_mask (line_mask),
            .addr      (curr_set),
            .wdata     (line_wdata),
            .rdata     (data_rdata[w])
        );

        sram_array #(.WIDTH(`CACHE_TAG_BITS + 1)) u_tag (
            .clk       (clk),
            .select    (array_select),
            .write_en  (way_write_en[w]),
            .byte_mask ({TAG_BYTES{1'b1}}),
            .addr      (curr_set),
            .wdata     (tag_wdata),
            .rdata     (tag_rdata[w])
        );

        ff_array #(.WIDTH(1)) u_valid (
            .clk      (clk),
            .rst      (rst),
            .select   (array_select),
            .write_en (way_write_en[w]),
            .addr     (curr_set),
            .wdata    (1'b1),
            .rdata    (valid_rdata[w])
        );
    end

    a_mask_exclusive: assert property (
        @(posedge clk) disable iff (rst) !((|ufp_rmask) && (|ufp_wmask))
    ) else $error("Read and write masks both set");

endmodule

/* testbench/tb_cache.sv */
`timescale 1ns/1ns
`include "cache_params.svh"

module tb_cache;

    logic                clk;
    logic                rst;
    mem_pkg::addr_t      ufp_addr;
    mem_pkg::byte_mask_t ufp_rmask;
    mem_pkg::byte_mask_t ufp_wmask;
    mem_pkg::word_t      ufp_rdata;
    mem_pkg::word_t      ufp_wdata;
    logic                ufp_resp;
    mem_pkg::addr_t      dfp_addr;
    logic                dfp_read;
    logic                dfp_write;
    mem_pkg::line_t      dfp_rdata;
    mem_pkg::line_t      dfp_wdata;
    logic                dfp_resp;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit timed_out = 0;

    mem_pkg::line_t mem_store [mem_pkg::addr_t];   // Lines held by the memory
    mem_pkg::line_t shadow [mem_pkg::addr_t];      // Value each line should have
    bit             log_wr [$];
    mem_pkg::addr_t log_addr [$];
    mem_pkg::line_t log_data [$];

    logic [`CACHE_TAG_BITS-1:0] m_tag [`CACHE_SETS][`CACHE_WAYS];
    bit                         m_valid [`CACHE_SETS][`CACHE_WAYS];
    bit                         m_dirty [`CACHE_SETS][`CACHE_WAYS];
    bit [2:0]                   m_plru [`CACHE_SETS];   // {b2, b1, b0}

    bit             resp_wr;
    mem_pkg::addr_t resp_addr;
    int             resp_delay;

    cache UUT (.*);

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory responder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always begin
        @(negedge clk);
        if (!rst && (dfp_read || dfp_write)) begin
            resp_wr = dfp_write;
            resp_addr = dfp_addr;
            log_wr.push_back(dfp_write);
            log_addr.push_back(dfp_addr);
            log_data.push_back(dfp_wdata);
            if (resp_wr) begin
                mem_store[resp_addr] = dfp_wdata;
            end
            resp_delay = $urandom_range(1, 6);
            repeat (resp_delay) @(posedge clk);
            #5;
            dfp_rdata = resp_wr ? '0 : mem_value(resp_addr);
            dfp_resp = 1'b1;
            @(posedge clk);
            #5;
            dfp_resp = 1'b0;
        end
    end

    function automatic mem_pkg::line_t initial_line(input mem_pkg::addr_t a);
        mem_pkg::line_t line;
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = (a + i * 4) ^ {a[15:0], a[31:16]} ^ 32'h6c3e91a7;
        end
        return line;
    endfunction

    function automatic mem_pkg::line_t mem_value(input mem_pkg::addr_t a);
        return mem_store.exists(a) ? mem_store[a] : initial_line(a);
    endfunction

    function automatic mem_pkg::line_t shadow_value(input mem_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : initial_line(a);
    endfunction

    function automatic int victim_of(input bit [2:0] b);
        if (!b[0]) begin
            return b[1] ? 1 : 0;
        end
        return b[2] ? 3 : 2;
    endfunction

    function automatic bit [2:0] touched(input bit [2:0] b, input int way);
        bit [2:0] n;
        n = b;
        case (way)
            0: n[1:0] = 2'b11;
            1: n[1:0] = 2'b01;
            2: n = {1'b1, n[1], 1'b0};
            default: n = {1'b0, n[1], 1'b0};
        endcase
        return n;
    endfunction

    function automatic void model_reset();
        mem_pkg::addr_t a;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (m_valid[s][w] && m_dirty[s][w]) begin
                    a = {m_tag[s][w], 4'(s), 5'b0};
                    shadow[a] = mem_value(a);   // Dirty data never reached memory
                end
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
            m_plru[s] = '0;
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string test, input mem_pkg::word_t exp,
                              input mem_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: word expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_line(input string test, input mem_pkg::line_t exp,
                              input mem_pkg::line_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: line expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_addr(input string test, input mem_pkg::addr_t exp,
                              input mem_pkg::addr_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: address expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_count(input string test, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            errors++;
            $display("ERR %s: %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_request(input string test, input bit is_write, input mem_pkg::addr_t addr,
                               input mem_pkg::byte_mask_t mask, input mem_pkg::word_t wdata);
        mem_pkg::addr_t line_a;
        mem_pkg::addr_t victim_a;
        mem_pkg::line_t line;
        mem_pkg::word_t rdata;
        bit             exp_wr [$];
        mem_pkg::addr_t exp_addr [$];
        mem_pkg::line_t exp_data [$];
        int             set;
        int             word;
        int             way;
        int             cycles;
        bit             got;

        if (timed_out) begin
            return;
        end
        line_a = {addr[31:5], 5'b0};
        set = addr[8:5];
        word = addr[4:2];
        way = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == addr[31:9]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = victim_of(m_plru[set]);
            if (m_valid[set][way] && m_dirty[set][way]) begin
                victim_a = {m_tag[set][way], addr[8:5], 5'b0};
                exp_wr.push_back(1'b1);
                exp_addr.push_back(victim_a);
                exp_data.push_back(shadow_value(victim_a));
            end
            exp_wr.push_back(1'b0);
            exp_addr.push_back(line_a);
            exp_data.push_back('0);
            m_tag[set][way] = addr[31:9];
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end
        m_plru[set] = touched(m_plru[set], way);
        line = shadow_value(line_a);
        if (is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    line[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            shadow[line_a] = line;
            m_dirty[set][way] = 1'b1;
        end

        log_wr.delete();
        log_addr.delete();
        log_data.delete();
        ufp_addr = addr;
        ufp_wdata = wdata;
        if (is_write) begin
            ufp_wmask = mask;
        end else begin
            ufp_rmask = 4'hf;
        end
        cycles = 0;
        got = 1'b0;
        while (!got && cycles < 200) begin
            @(negedge clk);
            cycles++;
            got = ufp_resp;
        end
        rdata = ufp_rdata;
        @(posedge clk);
        #5;
        ufp_rmask = '0;
        ufp_wmask = '0;
        if (!got) begin
            $display("Timeout in %s: no ufp_resp within 200 cycles", test);
            errors++;
            timed_out = 1'b1;
            return;
        end

        if (!is_write) begin
            check_word(test, line[word*32 +: 32], rdata);
        end
        if (exp_wr.size() == 0) begin
            check_count(test, "hit response edges", 2, cycles);
        end
        check_count(test, "memory transfers", exp_wr.size(), log_wr.size());
        for (int i = 0; i < exp_wr.size() && i < log_wr.size(); i++) begin
            check_count(test, "transfer is write", exp_wr[i], log_wr[i]);
            check_addr(test, exp_addr[i], log_addr[i]);
            if (exp_wr[i]) begin
                check_line(test, exp_data[i], log_data[i]);
            end
        end
    endtask

    task automatic cpu_read(input string test, input mem_pkg::addr_t addr);
        run_request(test, 1'b0, addr, 4'hf, '0);
    endtask

    task automatic cpu_write(input string test, input mem_pkg::addr_t addr,
                             input mem_pkg::byte_mask_t mask, input mem_pkg::word_t data);
        run_request(test, 1'b1, addr, mask, data);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    task automatic report_test(input string test, input int start);
        if (errors == start && !timed_out) begin
            tests_passed++;
            $display("%-14s ok", test);
        end else begin
            tests_failed++;
            $display("%-14s failed with %0d errors", test, errors - start);
        end
    endtask

    function automatic mem_pkg::addr_t line_in_set(input int tag, input int set);
        return {23'(tag), 4'(set), 5'b0};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_cold_miss();
        int start;
        start = errors;
        cpu_read("cold_miss", 32'h0000_1004);   // Fetches the line
        cpu_read("cold_miss", 32'h0000_1018);
        report_test("cold_miss", start);
    endtask

    task automatic test_write_hit();
        int start;
        start = errors;
        cpu_write("write_hit", 32'h0000_1008, 4'b0101, 32'hdead_beef);
        cpu_read("write_hit", 32'h0000_1008);
        cpu_read("write_hit", 32'h0000_100c);   // Neighbour word untouched
        report_test("write_hit", start);
    endtask

    task automatic test_plru_evict();
        int start;
        start = errors;
        for (int t = 1; t <= 4; t++) begin
            cpu_write("plru_evict", line_in_set(t, 3), 4'hf, 32'h1000_0000 + t);
        end
        cpu_read("plru_evict", line_in_set(1, 3));
        cpu_write("plru_evict", line_in_set(5, 3), 4'b0011, 32'h5555_aaaa);   // Dirty victim
        report_test("plru_evict", start);
    endtask

    task automatic test_clean_victim();
        int start;
        start = errors;
        for (int t = 1; t <= 5; t++) begin
            cpu_read("clean_victim", line_in_set(t, 7) + 4);
        end
        cpu_read("clean_victim", line_in_set(2, 3));   // Written back earlier
        report_test("clean_victim", start);
    endtask

    task automatic test_reset();
        int start;
        int cycles;
        start = errors;
        cpu_read("reset", 32'h0000_1004);
        ufp_addr = 32'h0000_0184;   // Cold line in set 12 so reset lands during its fill
        ufp_rmask = 4'hf;
        cycles = 0;
        while (!dfp_read && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!dfp_read) begin
            $display("Timeout in reset: no dfp_read within 200 cycles");
            errors++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        #5;
        ufp_rmask = '0;
        apply_reset();
        model_reset();
        @(negedge clk);
        check_count("reset", "ufp_resp", 0, ufp_resp);
        check_count("reset", "dfp_read", 0, dfp_read);
        check_count("reset", "dfp_write", 0, dfp_write);
        @(posedge clk);
        #5;
        cpu_read("reset", 32'h0000_1004);
        report_test("reset", start);
    endtask

    task automatic test_random();
        int             start;
        int             line;
        mem_pkg::addr_t addr;
        start = errors;
        line = 0;
        for (int i = 0; i < 300; i++) begin
            if ($urandom_range(0, 1) == 0) begin
                line = $urandom_range(0, 63);   // Else stay on the line for more hits
            end
            addr = 32'h0010_0000 + line[5:3] * 512 + line[2:0] * 32 + $urandom_range(0, 7) * 4;
            if ($urandom_range(0, 1) == 0) begin
                cpu_write("random", addr, $urandom_range(1, 15), $urandom());
            end else begin
                cpu_read("random", addr);
            end
        end
        report_test("random", start);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        dfp_rdata = '0;
        dfp_resp = 1'b0;
        void'($urandom(32'h0b916df9));
        apply_reset();

        test_cold_miss();
        test_write_hit();
        test_plru_evict();
        test_clean_victim();
        test_reset();
        test_random();

        $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
source/sram_array.sv
source/ff_array.sv
cache/cache_fsm.sv
cache/hit_miss.sv
cache/plru.sv
cache/cache.sv
testbench/tb_cache.sv

/* Bender.yml */
package:
  name: cache

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cache_pkg.sv
      - common/mem_pkg.sv
      - source/sram_array.sv
      - source/ff_array.sv
      - cache/cache_fsm.sv
      - cache/hit_miss.sv
      - cache/plru.sv
      - cache/cache.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_cache.sv
